//--- Bender.yml
package:
  name: n64_glue

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/n64_glue_pkg.sv
      - rtl/pifrom_loader.sv
      - rtl/cart_loader.sv
      - rtl/aspect_ratio.sv
      - rtl/snac_port_mux.sv
      - rtl/n64_glue_top.sv
  - target: simulation
    include_dirs:
      - rtl
    files:
      - sim/n64_glue_props.sv
      - sim/n64_glue_tb.sv

//--- rtl/aspect_ratio.sv
//======================================================================
// Video aspect ratio from region, vertical crop and aspect mode
//======================================================================
`timescale 1ns/1ps
`include "n64_glue_params.svh"

module aspect_ratio
	import n64_glue_pkg::*;
(
	input  logic       clk_1x,
	input  logic       RESET,
	input  video_cfg_t cfg,
	output ar_out_t    video_arx,
	output ar_out_t    video_ary
);

	ar_coord_t core_x;
	ar_coord_t core_y;
	ar_coord_t core_x_nxt;
	ar_coord_t core_y_nxt;
	ar_out_t   arx_q;
	ar_out_t   ary_q;

	// Core ratio, crop 3 keeps the old one
	always_comb begin
		core_x_nxt = core_x;
		core_y_nxt = core_y;
		if (cfg.blanks_fixed_off || cfg.direct_fb) begin
			core_x_nxt = `N64_AR_DEF_X;
			core_y_nxt = `N64_AR_DEF_Y;
		end else if (cfg.is_pal) begin
			case (cfg.crop)
				2'd0: begin
					core_x_nxt = `N64_AR_PAL_X0;
					core_y_nxt = `N64_AR_PAL_Y0;
				end
				2'd1: begin
					core_x_nxt = `N64_AR_PAL_X1;
					core_y_nxt = `N64_AR_PAL_Y1;
				end
				2'd2: begin
					core_x_nxt = `N64_AR_PAL_X2;
					core_y_nxt = `N64_AR_PAL_Y2;
				end
				default: ;
			endcase
		end else begin
			case (cfg.crop)
				2'd0: begin
					core_x_nxt = `N64_AR_NTSC_X0;
					core_y_nxt = `N64_AR_NTSC_Y0;
				end
				2'd1: begin
					core_x_nxt = `N64_AR_NTSC_X1;
					core_y_nxt = `N64_AR_NTSC_Y1;
				end
				2'd2: begin
					core_x_nxt = `N64_AR_NTSC_X2;
					core_y_nxt = `N64_AR_NTSC_Y2;
				end
				default: ;
			endcase
		end
	end

	// Modes 1..3 pass the scaler code, ary zero
	always_ff @(posedge clk_1x) begin
		if (!RESET) begin
			core_x <= `N64_AR_DEF_X;
			core_y <= `N64_AR_DEF_Y;
			arx_q  <= {1'b0, `N64_AR_DEF_X};
			ary_q  <= {1'b0, `N64_AR_DEF_Y};
		end else begin
			core_x <= core_x_nxt;
			core_y <= core_y_nxt;
			if (cfg.aspect_mode == 2'd0) begin
				arx_q <= {1'b0, core_x_nxt};
				ary_q <= {1'b0, core_y_nxt};
			end else begin
				arx_q <= {11'd0, cfg.aspect_mode - 2'd1};
				ary_q <= '0;
			end
		end
	end

	assign video_arx = arx_q;
	assign video_ary = ary_q;

endmodule

//--- rtl/cart_loader.sv
//======================================================================
// Cartridge download: loaded flag, ROM copy start and GB image writes
// GB halves go to SDRAM as 32-bit words, host stalls via ioctl_wait
//======================================================================
`timescale 1ns/1ps
`include "n64_glue_params.svh"

module cart_loader
	import n64_glue_pkg::*;
(
	input  logic        clk_1x,
	input  logic        RESET,
	input  ioctl_bus_t  ioctl,
	output ram_wr_t     ram_wr,
	input  logic        ram_ready,
	output logic        ioctl_wait,
	output logic        cart_loaded,
	output logic        romcopy_start,
	output ioctl_addr_t romcopy_size
);

	logic        n64_active;
	logic        gb_active;
	logic        download_q;
	logic        loaded_q;
	logic        start_q;
	logic        cart_end;
	ioctl_addr_t size_q;
	cart_state_t state;
	logic        req_q;
	ioctl_addr_t wr_addr_q;
	word_t       wr_data_q;
	logic        even_wr;
	logic        odd_wr;

	// N64 download just ended
	assign cart_end = !ioctl.download && download_q && (ioctl.index[5:0] == `N64_IDX_CART);

	assign even_wr = gb_active && ioctl.wr && !ioctl.addr[1];
	assign odd_wr  = gb_active && ioctl.wr && ioctl.addr[1];

	//==================================================================
	// N64 cartridge
	//==================================================================
	always_ff @(posedge clk_1x) begin
		if (!RESET) begin
			n64_active <= 1'b0;
			gb_active  <= 1'b0;
			download_q <= 1'b0;
			loaded_q   <= 1'b0;
			start_q    <= 1'b0;
		end else begin
			n64_active <= ioctl.download && (ioctl.index[5:0] == `N64_IDX_CART);
			gb_active  <= ioctl.download && (ioctl.index[5:0] == `N64_IDX_GB);
			download_q <= ioctl.download;
			start_q    <= cart_end;
			// Sticky until reset
			if (n64_active)
				loaded_q <= 1'b1;
		end
	end

	// Last address is the image size
	always_ff @(posedge clk_1x) begin
		if (cart_end)
			size_q <= ioctl.addr;
	end

	//==================================================================
	// GB transfer cartridge
	//==================================================================
	always_ff @(posedge clk_1x) begin
		if (!RESET) begin
			state <= CART_IDLE;
			req_q <= 1'b0;
		end else begin
			req_q <= 1'b0;
			if (!gb_active) begin
				state <= CART_IDLE;
			end else begin
				case (state)
					CART_IDLE, CART_HALF: begin
						if (odd_wr) begin
							state <= CART_WAIT;
							req_q <= 1'b1;
						end else if (even_wr) begin
							state <= CART_HALF;
						end
					end
					CART_WAIT: begin
						if (ram_ready)
							state <= CART_IDLE;
					end
					default: state <= CART_IDLE;
				endcase
			end
		end
	end

	// Halves are captured outside the stall only
	always_ff @(posedge clk_1x) begin
		if (state != CART_WAIT) begin
			if (even_wr) begin
				wr_data_q[15:0] <= ioctl.data;
				wr_addr_q       <= ioctl.addr + `N64_GB_BASE;
			end
			if (odd_wr)
				wr_data_q[31:16] <= ioctl.data;
		end
	end

	assign ram_wr        = '{req: req_q, addr: wr_addr_q, data: wr_data_q};
	assign ioctl_wait    = (state == CART_WAIT);
	assign cart_loaded   = loaded_q;
	assign romcopy_start = start_q;
	assign romcopy_size  = size_q;

endmodule

//--- rtl/n64_glue_params.svh
//======================================================================
// Shared constants for the loader and board glue around the N64 core
// Include wherever widths, index codes or table values are needed
//======================================================================
`ifndef N64_GLUE_PARAMS_SVH
`define N64_GLUE_PARAMS_SVH

// Bus widths
`define N64_IOCTL_ADDR_W 27
`define N64_IOCTL_DATA_W 16
`define N64_INDEX_W 8
`define N64_WORD_W 32
`define N64_PIF_ADDR_W 10
`define N64_AR_COORD_W 12
`define N64_AR_OUT_W 13
`define N64_USER_PIN_W 7

// Download index codes, low 6 index bits
`define N64_IDX_PIF 6'd0
`define N64_IDX_CART 6'd1
`define N64_IDX_GB 6'd2

// SDRAM byte address of the GB cartridge image
`define N64_GB_BASE 27'd8388608

// User port pins per pad
`define N64_PIN_PAD0 3'd1
`define N64_PIN_PAD1 3'd0
`define N64_PIN_PAD2 3'd5
`define N64_PIN_PAD3 3'd4
`define N64_PIN_HIGH_MASK 7'b1001100

// Aspect ratio table
`define N64_AR_DEF_X 12'd4
`define N64_AR_DEF_Y 12'd3
`define N64_AR_NTSC_X0 12'd512
`define N64_AR_NTSC_Y0 12'd381
`define N64_AR_NTSC_X1 12'd1280
`define N64_AR_NTSC_Y1 12'd889
`define N64_AR_NTSC_X2 12'd2560
`define N64_AR_NTSC_Y2 12'd1714
`define N64_AR_PAL_X0 12'd512
`define N64_AR_PAL_Y0 12'd387
`define N64_AR_PAL_X1 12'd1024
`define N64_AR_PAL_Y1 12'd731
`define N64_AR_PAL_X2 12'd2048
`define N64_AR_PAL_Y2 12'd1419

`endif

//--- rtl/n64_glue_pkg.sv
//======================================================================
// Types shared by the glue blocks: vectors, bus structs, loader FSM
//======================================================================
`include "n64_glue_params.svh"

package n64_glue_pkg;

	typedef logic [`N64_IOCTL_ADDR_W-1:0] ioctl_addr_t;
	typedef logic [`N64_IOCTL_DATA_W-1:0] ioctl_data_t;
	typedef logic [`N64_WORD_W-1:0]       word_t;
	typedef logic [`N64_PIF_ADDR_W-1:0]   pif_addr_t;
	typedef logic [`N64_AR_COORD_W-1:0]   ar_coord_t;
	typedef logic [`N64_AR_OUT_W-1:0]     ar_out_t;
	typedef logic [1:0]                   pad_idx_t;
	typedef logic [`N64_USER_PIN_W-1:0]   user_pins_t;

	// Host download stream
	typedef struct packed {
		logic                    download;
		logic [`N64_INDEX_W-1:0] index;
		ioctl_addr_t             addr;
		ioctl_data_t             data;
		logic                    wr;
	} ioctl_bus_t;

	// Boot ROM write port
	typedef struct packed {
		logic      wren;
		pif_addr_t addr;
		word_t     data;
	} pif_wr_t;

	// SDRAM write request
	typedef struct packed {
		logic        req;
		ioctl_addr_t addr;
		word_t       data;
	} ram_wr_t;

	// Video settings from the menu
	typedef struct packed {
		logic       is_pal;
		logic [1:0] crop;
		logic [1:0] aspect_mode;
		logic       blanks_fixed_off;
		logic       direct_fb;
	} video_cfg_t;

	typedef enum logic [1:0] {
		CART_IDLE,
		CART_HALF,
		CART_WAIT
	} cart_state_t;

endpackage

//--- rtl/n64_glue_top.sv
//======================================================================
// Glue top level: boot ROM loader, cart loader, aspect and SNAC pins
//======================================================================
`timescale 1ns/1ps
`include "n64_glue_params.svh"

module n64_glue_top
	import n64_glue_pkg::*;
(
	input  logic        clk_1x,
	input  logic        RESET,
	// Host download
	input  ioctl_bus_t  ioctl,
	output logic        ioctl_wait,
	output pif_wr_t     pif_wr,
	// SDRAM and core
	output ram_wr_t     ram_wr,
	input  logic        ram_ready,
	output logic        cart_loaded,
	output logic        romcopy_start,
	output ioctl_addr_t romcopy_size,
	// Video
	input  video_cfg_t  cfg,
	output ar_out_t     video_arx,
	output ar_out_t     video_ary,
	// SNAC
	input  logic        snac_en,
	input  pad_idx_t    pad_idx,
	input  logic        snac_dout,
	output logic        snac_din,
	input  user_pins_t  user_in,
	output user_pins_t  user_out
);

	pifrom_loader u_pifrom_loader (
		.clk_1x (clk_1x),
		.RESET  (RESET),
		.ioctl  (ioctl),
		.pif_wr (pif_wr)
	);

	cart_loader u_cart_loader (
		.clk_1x        (clk_1x),
		.RESET         (RESET),
		.ioctl         (ioctl),
		.ram_wr        (ram_wr),
		.ram_ready     (ram_ready),
		.ioctl_wait    (ioctl_wait),
		.cart_loaded   (cart_loaded),
		.romcopy_start (romcopy_start),
		.romcopy_size  (romcopy_size)
	);

	aspect_ratio u_aspect_ratio (
		.clk_1x    (clk_1x),
		.RESET     (RESET),
		.cfg       (cfg),
		.video_arx (video_arx),
		.video_ary (video_ary)
	);

	snac_port_mux u_snac_port_mux (
		.clk_1x    (clk_1x),
		.RESET     (RESET),
		.snac_en   (snac_en),
		.pad_idx   (pad_idx),
		.snac_dout (snac_dout),
		.snac_din  (snac_din),
		.user_in   (user_in),
		.user_out  (user_out)
	);

endmodule

//--- rtl/pifrom_loader.sv
//======================================================================
// Boot ROM download, packs two host halves into one byte-swapped word
//======================================================================
`timescale 1ns/1ps
`include "n64_glue_params.svh"

module pifrom_loader
	import n64_glue_pkg::*;
(
	input  logic       clk_1x,
	input  logic       RESET,
	input  ioctl_bus_t ioctl,
	output pif_wr_t    pif_wr
);

	logic      pif_active;
	logic      wren_q;
	pif_addr_t addr_q;
	word_t     data_q;

	// Download flag and write strobe
	always_ff @(posedge clk_1x) begin
		if (!RESET) begin
			pif_active <= 1'b0;
			wren_q     <= 1'b0;
		end else begin
			pif_active <= ioctl.download && (ioctl.index[5:0] == `N64_IDX_PIF);
			wren_q     <= pif_active && ioctl.wr && ioctl.addr[1];
		end
	end

	// Word assembly, bytes swapped within each half
	always_ff @(posedge clk_1x) begin
		if (pif_active && ioctl.wr) begin
			if (!ioctl.addr[1]) begin
				data_q[31:24] <= ioctl.data[7:0];
				data_q[23:16] <= ioctl.data[15:8];
				// Index bit 6 picks the upper ROM half
				addr_q        <= {ioctl.index[6], ioctl.addr[10:2]};
			end else begin
				data_q[15:8] <= ioctl.data[7:0];
				data_q[7:0]  <= ioctl.data[15:8];
			end
		end
	end

	assign pif_wr = '{wren: wren_q, addr: addr_q, data: data_q};

endmodule

//--- rtl/snac_port_mux.sv
//======================================================================
// SNAC data line routing onto the open-drain user port by pad number
//======================================================================
`timescale 1ns/1ps
`include "n64_glue_params.svh"

module snac_port_mux
	import n64_glue_pkg::*;
(
	input  logic       clk_1x,
	input  logic       RESET,
	input  logic       snac_en,
	input  pad_idx_t   pad_idx,
	input  logic       snac_dout,
	output logic       snac_din,
	input  user_pins_t user_in,
	output user_pins_t user_out
);

	logic [2:0] pad_pin;
	user_pins_t user_nxt;
	user_pins_t user_q;
	logic       din_q;

	// Pad number to pin
	always_comb begin
		case (pad_idx)
			2'd0:    pad_pin = `N64_PIN_PAD0;
			2'd1:    pad_pin = `N64_PIN_PAD1;
			2'd2:    pad_pin = `N64_PIN_PAD2;
			default: pad_pin = `N64_PIN_PAD3;
		endcase
	end

	// Unused pad pins keep their level, pins 2/3/6 stay released
	always_comb begin
		user_nxt          = user_q | `N64_PIN_HIGH_MASK;
		user_nxt[pad_pin] = snac_dout;
	end

	always_ff @(posedge clk_1x) begin
		if (!RESET) begin
			user_q <= '1;
			din_q  <= 1'b0;
		end else if (snac_en) begin
			user_q <= user_nxt;
			din_q  <= user_in[pad_pin];
		end else begin
			// All high so the port can be read
			user_q <= '1;
		end
	end

	assign user_out = user_q;
	assign snac_din = din_q;

endmodule

//--- sim.f
+incdir+rtl
rtl/n64_glue_pkg.sv
rtl/pifrom_loader.sv
rtl/cart_loader.sv
rtl/aspect_ratio.sv
rtl/snac_port_mux.sv
rtl/n64_glue_top.sv
sim/n64_glue_props.sv
sim/n64_glue_tb.sv

//--- sim/n64_glue_props.sv
//======================================================================
// Reference model and concurrent checks for the glue top level
// Bound into n64_glue_top and counts failures in fail_cnt
//======================================================================
`timescale 1ns/1ps
`include "n64_glue_params.svh"

module n64_glue_props
	import n64_glue_pkg::*;
(
	input logic        clk_1x,
	input logic        RESET,
	input ioctl_bus_t  ioctl,
	input logic        ioctl_wait,
	input pif_wr_t     pif_wr,
	input ram_wr_t     ram_wr,
	input logic        ram_ready,
	input logic        cart_loaded,
	input logic        romcopy_start,
	input ioctl_addr_t romcopy_size,
	input video_cfg_t  cfg,
	input ar_out_t     video_arx,
	input ar_out_t     video_ary,
	input logic        snac_en,
	input pad_idx_t    pad_idx,
	input logic        snac_dout,
	input logic        snac_din,
	input user_pins_t  user_in,
	input user_pins_t  user_out
);

	int          fail_cnt = 0;
	logic        pif_act;
	logic        gb_act;
	logic        n64_act;
	logic        download_q;
	logic [15:0] pif_upper;
	word_t       exp_pif_data;
	pif_addr_t   exp_pif_addr;
	ioctl_data_t gb_lower;
	ioctl_addr_t gb_addr;
	word_t       exp_ram_data;
	ioctl_addr_t exp_ram_addr;
	logic [23:0] core_ratio;
	logic [23:0] core_next;
	ar_out_t     exp_arx;
	ar_out_t     exp_ary;
	logic [2:0]  pin_sel;
	logic        pif_even;
	logic        pif_odd;
	logic        gb_even;
	logic        gb_odd;
	logic        cart_end;

	task automatic note_failure(input string msg);
		fail_cnt++;
		$error("%s", msg);
	endtask

	// Ratio packed as {x, y}
	// Crop 3 keeps the previous entry
	function automatic logic [23:0] ratio_for(input video_cfg_t c, input logic [23:0] prev);
		logic [23:0] r;
		r = prev;
		if (c.blanks_fixed_off || c.direct_fb) begin
			r = {`N64_AR_DEF_X, `N64_AR_DEF_Y};
		end else begin
			case ({c.is_pal, c.crop})
				3'b000:  r = {`N64_AR_NTSC_X0, `N64_AR_NTSC_Y0};
				3'b001:  r = {`N64_AR_NTSC_X1, `N64_AR_NTSC_Y1};
				3'b010:  r = {`N64_AR_NTSC_X2, `N64_AR_NTSC_Y2};
				3'b100:  r = {`N64_AR_PAL_X0, `N64_AR_PAL_Y0};
				3'b101:  r = {`N64_AR_PAL_X1, `N64_AR_PAL_Y1};
				3'b110:  r = {`N64_AR_PAL_X2, `N64_AR_PAL_Y2};
				default: r = prev;
			endcase
		end
		return r;
	endfunction

	function automatic logic [2:0] pin_of(input pad_idx_t p);
		logic [2:0] pin;
		case (p)
			2'd0:    pin = `N64_PIN_PAD0;
			2'd1:    pin = `N64_PIN_PAD1;
			2'd2:    pin = `N64_PIN_PAD2;
			default: pin = `N64_PIN_PAD3;
		endcase
		return pin;
	endfunction

	assign pif_even  = pif_act && ioctl.wr && !ioctl.addr[1];
	assign pif_odd   = pif_act && ioctl.wr && ioctl.addr[1];
	assign gb_even   = gb_act && ioctl.wr && !ioctl.addr[1];
	assign gb_odd    = gb_act && ioctl.wr && ioctl.addr[1];
	assign cart_end  = download_q && !ioctl.download && (ioctl.index[5:0] == `N64_IDX_CART);
	assign core_next = ratio_for(cfg, core_ratio);
	assign pin_sel   = pin_of(pad_idx);

	//==================================================================
	// Reference model
	//==================================================================
	always_ff @(posedge clk_1x) begin
		if (!RESET) begin
			pif_act    <= 1'b0;
			gb_act     <= 1'b0;
			n64_act    <= 1'b0;
			download_q <= 1'b0;
			core_ratio <= {`N64_AR_DEF_X, `N64_AR_DEF_Y};
			exp_arx    <= 13'd4;
			exp_ary    <= 13'd3;
		end else begin
			pif_act    <= ioctl.download && (ioctl.index[5:0] == `N64_IDX_PIF);
			gb_act     <= ioctl.download && (ioctl.index[5:0] == `N64_IDX_GB);
			n64_act    <= ioctl.download && (ioctl.index[5:0] == `N64_IDX_CART);
			download_q <= ioctl.download;
			core_ratio <= core_next;
			if (cfg.aspect_mode == 2'd0) begin
				exp_arx <= {1'b0, core_next[23:12]};
				exp_ary <= {1'b0, core_next[11:0]};
			end else begin
				exp_arx <= ar_out_t'(cfg.aspect_mode) - ar_out_t'(1);
				exp_ary <= '0;
			end
		end
	end

	// Expected words from the host halves
	always_ff @(posedge clk_1x) begin
		if (pif_even) begin
			pif_upper    <= {ioctl.data[7:0], ioctl.data[15:8]};
			exp_pif_addr <= {ioctl.index[6], ioctl.addr[10:2]};
		end
		if (pif_odd)
			exp_pif_data <= {pif_upper, ioctl.data[7:0], ioctl.data[15:8]};
		if (gb_even) begin
			gb_lower <= ioctl.data;
			gb_addr  <= ioctl.addr + `N64_GB_BASE;
		end
		if (gb_odd) begin
			exp_ram_data <= {ioctl.data, gb_lower};
			exp_ram_addr <= gb_addr;
		end
	end

	//==================================================================
	// Assertions
	//==================================================================
	a_reset_state: assert property (@(posedge clk_1x) !RESET |=>
		!pif_wr.wren && !ram_wr.req && !ioctl_wait && !romcopy_start && !cart_loaded &&
		video_arx == 13'd4 && video_ary == 13'd3 && user_out == '1)
		else note_failure("Outputs not idle or aspect not 4:3 after reset");

	a_pif_word: assert property (@(posedge clk_1x) disable iff (!RESET) pif_odd |=>
		pif_wr.wren && pif_wr.data == exp_pif_data && pif_wr.addr == exp_pif_addr)
		else note_failure($sformatf("FAIL pif_wr wren %h data exp %h got %h addr exp %h got %h",
			$sampled(pif_wr.wren), $sampled(exp_pif_data), $sampled(pif_wr.data),
			$sampled(exp_pif_addr), $sampled(pif_wr.addr)));

	a_pif_only: assert property (@(posedge clk_1x) disable iff (!RESET)
		pif_wr.wren |-> $past(pif_odd))
		else note_failure("Boot ROM write without a preceding upper half host write");

	a_gb_word: assert property (@(posedge clk_1x) disable iff (!RESET) gb_odd |=>
		ram_wr.req && ioctl_wait && ram_wr.data == exp_ram_data && ram_wr.addr == exp_ram_addr)
		else note_failure($sformatf("FAIL ram_wr req %h data exp %h got %h addr exp %h got %h",
			$sampled(ram_wr.req), $sampled(exp_ram_data), $sampled(ram_wr.data),
			$sampled(exp_ram_addr), $sampled(ram_wr.addr)));

	a_req_only: assert property (@(posedge clk_1x) disable iff (!RESET)
		ram_wr.req |-> $past(gb_odd))
		else note_failure("SDRAM request without a preceding upper half GB write");

	// Wait holds until the cycle after ram_ready
	a_wait_span: assert property (@(posedge clk_1x) disable iff (!RESET)
		ioctl_wait |=> (ioctl_wait != $past(ram_ready)))
		else note_failure("ioctl_wait did not hold until the cycle after ram_ready");

	a_no_stall_write: assert property (@(posedge clk_1x) disable iff (!RESET)
		ioctl_wait |-> !ioctl.wr)
		else note_failure("Host write issued while ioctl_wait was high");

	a_cart_loaded: assert property (@(posedge clk_1x) disable iff (!RESET)
		1'b1 |=> (cart_loaded == $past(n64_act || cart_loaded)))
		else note_failure("cart_loaded does not follow the N64 cart download");

	a_romcopy: assert property (@(posedge clk_1x) disable iff (!RESET) cart_end |=>
		romcopy_start && romcopy_size == $past(ioctl.addr))
		else note_failure($sformatf("FAIL romcopy_start %h romcopy_size exp %h got %h",
			$sampled(romcopy_start), $past(ioctl.addr), $sampled(romcopy_size)));

	a_romcopy_once: assert property (@(posedge clk_1x) disable iff (!RESET)
		romcopy_start |-> $past(cart_end))
		else note_failure("romcopy_start pulsed without the end of an N64 cart download");

	a_aspect: assert property (@(posedge clk_1x) disable iff (!RESET)
		video_arx == exp_arx && video_ary == exp_ary)
		else note_failure($sformatf("FAIL video_arx exp %h got %h, video_ary exp %h got %h",
			$sampled(exp_arx), $sampled(video_arx), $sampled(exp_ary), $sampled(video_ary)));

	a_snac_on: assert property (@(posedge clk_1x) disable iff (!RESET) snac_en |=>
		user_out[$past(pin_sel)] == $past(snac_dout) &&
		(user_out & `N64_PIN_HIGH_MASK) == `N64_PIN_HIGH_MASK &&
		snac_din == $past(user_in[pin_sel]))
		else note_failure($sformatf("FAIL user_out %h snac_din %h after pad %h dout %h in %h",
			$sampled(user_out), $sampled(snac_din), $past(pad_idx), $past(snac_dout),
			$past(user_in)));

	a_snac_off: assert property (@(posedge clk_1x) disable iff (!RESET)
		!snac_en |=> user_out == '1)
		else note_failure($sformatf("FAIL user_out exp 7f got %h", $sampled(user_out)));

endmodule

bind n64_glue_top n64_glue_props u_props (.*);

//--- sim/n64_glue_tb.sv
//======================================================================
// Testbench for the glue top level with an SDRAM model and timeout
// The bound n64_glue_props assertions do the checking
//======================================================================
`timescale 1ns/1ps
`include "n64_glue_params.svh"

module n64_glue_tb
	import n64_glue_pkg::*;
();

	// Run limit in clock cycles
	localparam int TIMEOUT_CYCLES = 4000;

	logic        clk_1x;
	logic        RESET;
	ioctl_bus_t  ioctl;
	logic        ioctl_wait;
	pif_wr_t     pif_wr;
	ram_wr_t     ram_wr;
	logic        ram_ready;
	logic        cart_loaded;
	logic        romcopy_start;
	ioctl_addr_t romcopy_size;
	video_cfg_t  cfg;
	ar_out_t     video_arx;
	ar_out_t     video_ary;
	logic        snac_en;
	pad_idx_t    pad_idx;
	logic        snac_dout;
	logic        snac_din;
	user_pins_t  user_in;
	user_pins_t  user_out;
	int          cycle_cnt = 0;
	int unsigned ready_delay;

	n64_glue_top DUT (
		.clk_1x        (clk_1x),
		.RESET         (RESET),
		.ioctl         (ioctl),
		.ioctl_wait    (ioctl_wait),
		.pif_wr        (pif_wr),
		.ram_wr        (ram_wr),
		.ram_ready     (ram_ready),
		.cart_loaded   (cart_loaded),
		.romcopy_start (romcopy_start),
		.romcopy_size  (romcopy_size),
		.cfg           (cfg),
		.video_arx     (video_arx),
		.video_ary     (video_ary),
		.snac_en       (snac_en),
		.pad_idx       (pad_idx),
		.snac_dout     (snac_dout),
		.snac_din      (snac_din),
		.user_in       (user_in),
		.user_out      (user_out)
	);

	always #2 clk_1x = ~clk_1x;

	// SDRAM answers each request 1 to 6 cycles later
	always begin
		@(posedge clk_1x);
		#1;
		if (ram_wr.req) begin
			ready_delay = $urandom_range(6, 1);
			repeat (ready_delay) @(posedge clk_1x);
			#1;
			ram_ready = 1'b1;
			@(posedge clk_1x);
			#1;
			ram_ready = 1'b0;
		end
	end

	always @(posedge clk_1x) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= TIMEOUT_CYCLES) begin
			$display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("Errors: %0d assertion failures, 1 timeout", DUT.u_props.fail_cnt);
			$display("=== FAIL ===");
			$finish;
		end
	end

	//==================================================================
	// Host side tasks
	//==================================================================
	task automatic next_cycle;
		@(posedge clk_1x);
		#1;
	endtask

	task automatic start_download(input logic [7:0] idx);
		ioctl.index    = idx;
		ioctl.download = 1'b1;
		next_cycle();
	endtask

	// Index and last address stay on the bus after the end
	task automatic end_download;
		while (ioctl_wait)
			next_cycle();
		ioctl.download = 1'b0;
		repeat (3) next_cycle();
	endtask

	task automatic host_write(input ioctl_addr_t a, input ioctl_data_t d);
		while (ioctl_wait)
			next_cycle();
		ioctl.addr = a;
		ioctl.data = d;
		ioctl.wr   = 1'b1;
		next_cycle();
		ioctl.wr = 1'b0;
		if ($urandom_range(3, 0) == 0)
			next_cycle();
	endtask

	task automatic load_words(input logic [7:0] idx, input int words);
		start_download(idx);
		for (int w = 0; w < words; w++) begin
			host_write(ioctl_addr_t'(w * 4), ioctl_data_t'($urandom));
			host_write(ioctl_addr_t'(w * 4 + 2), ioctl_data_t'($urandom));
		end
		end_download();
	endtask

	task automatic load_n64_cart;
		start_download(8'h01);
		for (int h = 0; h < 20; h++)
			host_write(ioctl_addr_t'(h * 2), ioctl_data_t'($urandom));
		end_download();
	endtask

	//==================================================================
	// Video and SNAC stimulus
	//==================================================================
	task automatic sweep_aspect;
		// Directed pass through crop 3 hold and the fixed 4:3 cases
		cfg.crop = 2'd1;
		next_cycle();
		cfg.crop = 2'd3;
		repeat (2) next_cycle();
		cfg.is_pal = 1'b1;
		cfg.crop   = 2'd2;
		next_cycle();
		cfg.crop = 2'd3;
		repeat (2) next_cycle();
		cfg.blanks_fixed_off = 1'b1;
		next_cycle();
		cfg.blanks_fixed_off = 1'b0;
		cfg.direct_fb        = 1'b1;
		next_cycle();
		cfg.direct_fb = 1'b0;
		repeat (2) next_cycle();
		repeat (48) begin
			cfg.is_pal           = 1'($urandom_range(1, 0));
			cfg.crop             = 2'($urandom_range(3, 0));
			cfg.aspect_mode      = ($urandom_range(1, 0) == 0) ? 2'd0 : 2'($urandom_range(3, 1));
			cfg.blanks_fixed_off = ($urandom_range(3, 0) == 0);
			cfg.direct_fb        = ($urandom_range(3, 0) == 0);
			repeat ($urandom_range(2, 1)) next_cycle();
		end
	endtask

	task automatic exercise_snac;
		repeat (60) begin
			snac_en   = ($urandom_range(3, 0) != 0);
			pad_idx   = pad_idx_t'($urandom_range(3, 0));
			snac_dout = 1'($urandom_range(1, 0));
			user_in   = user_pins_t'($urandom_range(127, 0));
			next_cycle();
		end
		snac_en = 1'b0;
		repeat (2) next_cycle();
	endtask

	initial begin
		void'($urandom(76524));
		clk_1x    = 1'b0;
		RESET     = 1'b0;
		ioctl     = '0;
		ram_ready = 1'b0;
		cfg       = '0;
		snac_en   = 1'b0;
		pad_idx   = '0;
		snac_dout = 1'b0;
		user_in   = '1;
		repeat (10) @(posedge clk_1x);
		#1;
		RESET = 1'b1;
		next_cycle();

		// Boot ROM lower half then upper half
		load_words(8'h00, 6);
		load_words(8'h40, 6);
		load_words(8'h02, 12);
		load_n64_cart();
		sweep_aspect();
		exercise_snac();
		repeat (4) next_cycle();

		$display("Errors: %0d assertion failures, 0 timeouts, %0d cycles",
			DUT.u_props.fail_cnt, cycle_cnt);
		if (DUT.u_props.fail_cnt == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

endmodule
